// ==== logic/expand_pkg.sv ====
/* Expand 1x1 shared definitions */
package expand_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////
	localparam int DATA_W    = 16;
	localparam int ACC_W     = 32;
	localparam int CHIN_NUM  = 16;
	localparam int LANE_NUM  = 8;
	localparam int PIXEL_NUM = 16;
	localparam int ADDR_W    = $clog2(CHIN_NUM);
	// Slot counter also covers the gap cycle
	localparam int SLOT_W    = $clog2(CHIN_NUM + 1);
	localparam int PIX_W     = $clog2(PIXEL_NUM + 1);
	// Requant window of the Q-format sum
	localparam int Q_LSB     = 14;
	localparam int Q_MSB     = Q_LSB + DATA_W - 2;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////
	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic signed [ACC_W-1:0]  acc_t;

	typedef struct packed {
		logic fire2_en;
		logic fire3_en;
	} layer_req_t;

	// Element selects keep the signed element type
	typedef data_t [LANE_NUM-1:0]             kern_vec_t;
	typedef acc_t  [LANE_NUM-1:0]             bias_vec_t;
	typedef acc_t  [LANE_NUM-1:0]             acc_vec_t;
	typedef logic  [LANE_NUM-1:0][DATA_W-1:0] ofm_vec_t;

	////////////////////////////////////////////////////////////
	// Parameter formulas
	////////////////////////////////////////////////////////////
	// Kernel pattern, spans about -135 to +135
	function automatic data_t layer_weight(input int layer, input int ch, input int lane);
		int w;
		w = ((ch * 7 + lane * 13 + layer * 5) % 31) - 15;
		return data_t'(w * 9);
	endfunction

	// Bias ramps across lanes, shifted per layer
	function automatic acc_t layer_bias(input int layer, input int lane);
		int b;
		b = (lane * 3 + layer * 4 - 10) * 1024;
		return acc_t'(b);
	endfunction

endpackage

// ==== logic/expand_param_rom.sv ====
/* Kernel and bias ROM */
`timescale 1ns/1ns

module expand_param_rom (
	input  logic                          clk,
	input  logic                          layer_sel_i,
	input  logic [expand_pkg::ADDR_W-1:0] addr_i,
	output expand_pkg::kern_vec_t         kern_o,
	output expand_pkg::bias_vec_t         bias_o
);

	// Index 0 is fire2, index 1 is fire3
	expand_pkg::kern_vec_t kern_tab [2][expand_pkg::CHIN_NUM];
	expand_pkg::bias_vec_t bias_tab [2];

	////////////////////////////////////////////////////////////
	// Constant tables
	////////////////////////////////////////////////////////////
	for (genvar g_l = 0; g_l < 2; g_l++) begin : g_layer
		for (genvar g_n = 0; g_n < expand_pkg::LANE_NUM; g_n++) begin : g_bias
			// One bias per lane, no channel dependence
			assign bias_tab[g_l][g_n] = expand_pkg::layer_bias(g_l, g_n);
		end
		for (genvar g_c = 0; g_c < expand_pkg::CHIN_NUM; g_c++) begin : g_chan
			for (genvar g_n = 0; g_n < expand_pkg::LANE_NUM; g_n++) begin : g_kern
				// Kernel of lane g_n for input channel g_c
				assign kern_tab[g_l][g_c][g_n] =
					expand_pkg::layer_weight(g_l, g_c, g_n);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Registered read
	////////////////////////////////////////////////////////////
	// One cycle latency, the top delays the pixel to match
	always_ff @(posedge clk) begin
		kern_o <= kern_tab[layer_sel_i][addr_i];
		// Bias follows the layer only
		bias_o <= bias_tab[layer_sel_i];
	end

endmodule

// ==== logic/mac_lane.sv ====
/* Signed MAC lane */
`timescale 1ns/1ns

module mac_lane (
	input  logic              clk,
	input  logic              rst_gen,
	input  logic              clr_i,
	input  logic              en_i,
	input  expand_pkg::data_t pix_i,
	input  expand_pkg::data_t ker_i,
	output expand_pkg::acc_t  acc_o
);

	expand_pkg::acc_t prod_c;

	// Full precision product, sign extended into the sum width
	assign prod_c = pix_i * ker_i;

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			acc_o <= '0;
		end else if (clr_i) begin
			// New pixel starts from its first product
			acc_o <= prod_c;
		end else if (en_i) begin
			acc_o <= acc_o + prod_c;
		end
	end

	// Clear only ever comes on a live channel slot
	a_clr_with_en: assert property (@(posedge clk) disable iff (rst_gen)
		clr_i |-> en_i);

endmodule

// ==== logic/expand_sequencer.sv ====
/* Expand layer sequencer */
`timescale 1ns/1ns

module expand_sequencer (
	input  logic                          clk,
	input  logic                          rst_gen,
	input  expand_pkg::layer_req_t        layer_i,
	output logic [expand_pkg::ADDR_W-1:0] rom_addr_o,
	output logic                          layer_sel_o,
	output logic                          lane_en_o,
	output logic                          acc_clr_o,
	output logic                          fire2_done_o,
	output logic                          fire3_done_o
);

	logic [expand_pkg::SLOT_W-1:0] slot_q;
	logic [expand_pkg::PIX_W-1:0]  f2_pix_q;
	logic [expand_pkg::PIX_W-1:0]  f3_pix_q;
	logic                          f2_done_q;
	logic                          f3_done_q;
	logic [1:0]                    f2_lag_q;
	logic [1:0]                    f3_lag_q;
	logic                          f2_act;
	logic                          f3_act;
	logic                          any_act;
	logic                          pix_end;

	////////////////////////////////////////////////////////////
	// Layer select
	////////////////////////////////////////////////////////////
	always_comb begin
		// Finished layers are masked out and fire2 wins a tie
		f2_act  = layer_i.fire2_en && !f2_done_q;
		f3_act  = layer_i.fire3_en && !f3_done_q && !f2_act;
		any_act = f2_act || f3_act;
		// Gap slot closes the pixel
		pix_end = any_act && (slot_q == expand_pkg::SLOT_W'(expand_pkg::CHIN_NUM));
	end

	////////////////////////////////////////////////////////////
	// Slot counter over CHIN_NUM channels and one gap
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			slot_q <= '0;
		end else if (!any_act || pix_end) begin
			slot_q <= '0;
		end else begin
			slot_q <= slot_q + 1'b1;
		end
	end

	assign lane_en_o   = any_act && (slot_q < expand_pkg::SLOT_W'(expand_pkg::CHIN_NUM));
	// First channel restarts the accumulators
	assign acc_clr_o   = any_act && (slot_q == '0);
	// Address parked at zero on the gap
	assign rom_addr_o  = lane_en_o ? slot_q[expand_pkg::ADDR_W-1:0] : '0;
	assign layer_sel_o = f3_act;

	////////////////////////////////////////////////////////////
	// Pixel counters and done flags
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			f2_pix_q  <= '0;
			f3_pix_q  <= '0;
			f2_done_q <= 1'b0;
			f3_done_q <= 1'b0;
		end else if (pix_end) begin
			if (f2_act) begin
				f2_pix_q <= f2_pix_q + 1'b1;
				if (f2_pix_q == expand_pkg::PIX_W'(expand_pkg::PIXEL_NUM - 1))
					f2_done_q <= 1'b1;
			end else begin
				f3_pix_q <= f3_pix_q + 1'b1;
				if (f3_pix_q == expand_pkg::PIX_W'(expand_pkg::PIXEL_NUM - 1))
					f3_done_q <= 1'b1;
			end
		end
	end

	// Done level waits out the lane and requant stages
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			f2_lag_q <= '0;
			f3_lag_q <= '0;
		end else begin
			f2_lag_q <= {f2_lag_q[0], f2_done_q};
			f3_lag_q <= {f3_lag_q[0], f3_done_q};
		end
	end

	assign fire2_done_o = f2_lag_q[1];
	assign fire3_done_o = f3_lag_q[1];

	// Slot never runs past the gap
	a_slot_range: assert property (@(posedge clk) disable iff (rst_gen)
		slot_q <= expand_pkg::SLOT_W'(expand_pkg::CHIN_NUM));
	// Done flag matches a full pixel count and the count stays frozen after it
	a_done_count: assert property (@(posedge clk) disable iff (rst_gen)
		(f2_done_q == (f2_pix_q == expand_pkg::PIX_W'(expand_pkg::PIXEL_NUM))) &&
		(f3_done_q == (f3_pix_q == expand_pkg::PIX_W'(expand_pkg::PIXEL_NUM))));

endmodule

// ==== logic/output_requant.sv ====
/* Bias, ReLU and requant */
`timescale 1ns/1ns

module output_requant (
	input  logic                  clk,
	input  logic                  rst_gen,
	input  logic                  sample_i,
	input  expand_pkg::acc_vec_t  acc_i,
	input  expand_pkg::bias_vec_t bias_i,
	output expand_pkg::ofm_vec_t  ofm_o,
	output logic                  ofm_valid_o
);

	expand_pkg::acc_vec_t sum_c;
	expand_pkg::ofm_vec_t q_c;

	////////////////////////////////////////////////////////////
	// Per lane bias add and slice
	////////////////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < expand_pkg::LANE_NUM; i++) begin
			sum_c[i] = acc_i[i] + bias_i[i];
			// ReLU on the sign bit
			if (sum_c[i][expand_pkg::ACC_W-1]) begin
				q_c[i] = '0;
			end else begin
				// Q-format window, top bit forced clear
				q_c[i] = {1'b0, sum_c[i][expand_pkg::Q_MSB:expand_pkg::Q_LSB]};
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////
	// Vector only loads on the sample
	always_ff @(posedge clk) begin
		if (sample_i)
			ofm_o <= q_c;
	end

	// Strobe lines up with the new vector
	always_ff @(posedge clk) begin
		if (rst_gen)
			ofm_valid_o <= 1'b0;
		else
			ofm_valid_o <= sample_i;
	end

endmodule

// ==== logic/expand_1x1_layer.sv ====
/* Fire2/fire3 expand 1x1 engine */
`timescale 1ns/1ns

module expand_1x1_layer (
	input  logic                   clk,
	input  logic                   rst_gen,
	input  expand_pkg::layer_req_t layer_i,
	input  expand_pkg::data_t      ifm_i,
	output expand_pkg::ofm_vec_t   ofm_o,
	output logic                   ofm_valid_o,
	output logic                   fire2_done_o,
	output logic                   fire3_done_o
);

	expand_pkg::layer_req_t        layer_q1;
	expand_pkg::layer_req_t        layer_q2;
	expand_pkg::data_t             ifm_q1;
	expand_pkg::data_t             ifm_q2;
	expand_pkg::data_t             ifm_q3;
	expand_pkg::data_t             pix_mux;
	logic [expand_pkg::ADDR_W-1:0] rom_addr;
	logic                          layer_sel;
	logic                          lane_en;
	logic                          acc_clr;
	logic                          lane_en_d1;
	logic                          lane_en_d2;
	logic                          acc_clr_d1;
	logic                          sample;
	expand_pkg::kern_vec_t         kern;
	expand_pkg::bias_vec_t         bias;
	expand_pkg::acc_vec_t          acc_vec;

	////////////////////////////////////////////////////////////
	// Input alignment
	////////////////////////////////////////////////////////////
	// Enables reset, pixel data just flows
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			layer_q1 <= '0;
			layer_q2 <= '0;
		end else begin
			layer_q1 <= layer_i;
			layer_q2 <= layer_q1;
		end
	end

	always_ff @(posedge clk) begin
		ifm_q1 <= ifm_i;
		ifm_q2 <= ifm_q1;
		// Extra stage matches the ROM read
		ifm_q3 <= ifm_q2;
	end

	expand_sequencer u_seq (
		.clk         (clk),
		.rst_gen     (rst_gen),
		.layer_i     (layer_q2),
		.rom_addr_o  (rom_addr),
		.layer_sel_o (layer_sel),
		.lane_en_o   (lane_en),
		.acc_clr_o   (acc_clr),
		.fire2_done_o(fire2_done_o),
		.fire3_done_o(fire3_done_o)
	);

	expand_param_rom u_rom (
		.clk        (clk),
		.layer_sel_i(layer_sel),
		.addr_i     (rom_addr),
		.kern_o     (kern),
		.bias_o     (bias)
	);

	////////////////////////////////////////////////////////////
	// Control delay to the lanes
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			lane_en_d1 <= 1'b0;
			lane_en_d2 <= 1'b0;
			acc_clr_d1 <= 1'b0;
		end else begin
			lane_en_d1 <= lane_en;
			lane_en_d2 <= lane_en_d1;
			acc_clr_d1 <= acc_clr;
		end
	end

	// Gap and idle cycles feed zero into the lanes
	assign pix_mux = lane_en_d1 ? ifm_q3 : '0;
	// Cycle after the last accumulate, sums are complete
	assign sample  = lane_en_d2 && !lane_en_d1;

	for (genvar g = 0; g < expand_pkg::LANE_NUM; g++) begin : g_lane
		mac_lane u_lane (
			.clk    (clk),
			.rst_gen(rst_gen),
			.clr_i  (acc_clr_d1),
			.en_i   (lane_en_d1),
			.pix_i  (pix_mux),
			.ker_i  (kern[g]),
			.acc_o  (acc_vec[g])
		);
	end

	output_requant u_requant (
		.clk        (clk),
		.rst_gen    (rst_gen),
		.sample_i   (sample),
		.acc_i      (acc_vec),
		.bias_i     (bias),
		.ofm_o      (ofm_o),
		.ofm_valid_o(ofm_valid_o)
	);

endmodule

// ==== verification/expand_checker.sv ====
/* Expand output checker */
`timescale 1ns/1ns

module expand_checker (
	input  logic                   clk,
	input  logic                   rst_gen,
	input  expand_pkg::layer_req_t layer_i,
	input  expand_pkg::data_t      ifm_i,
	input  expand_pkg::ofm_vec_t   ofm_i,
	input  logic                   ofm_valid_i,
	input  logic                   fire2_done_i,
	input  logic                   fire3_done_i,
	input  logic                   end_i,
	output int                     err_cnt_o,
	output int                     chk_cnt_o
);

	logic [expand_pkg::CHIN_NUM-1:0][expand_pkg::DATA_W-1:0] pix_buf;
	expand_pkg::ofm_vec_t exp_q [$];
	logic                 lay_q [$];
	expand_pkg::ofm_vec_t exp_v;
	logic                 exp_l;
	logic                 cur_l;
	logic                 f2_act;
	logic                 f3_act;
	logic [1:0]           done_m;
	logic [1:0]           done_now;
	logic [1:0]           done_prev;
	int                   slot;
	int                   pix_cnt [2];
	int                   str_cnt [2];

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	// Bias plus dot product, ReLU, then 15 bits from bit 14 up
	function automatic expand_pkg::ofm_vec_t ref_vector(input logic layer,
			input logic [expand_pkg::CHIN_NUM-1:0][expand_pkg::DATA_W-1:0] pix);
		expand_pkg::ofm_vec_t v;
		longint               sum;
		for (int n = 0; n < expand_pkg::LANE_NUM; n++) begin
			sum = longint'(expand_pkg::layer_bias(int'(layer), n));
			for (int c = 0; c < expand_pkg::CHIN_NUM; c++)
				sum += longint'($signed(pix[c])) *
					longint'(expand_pkg::layer_weight(int'(layer), c, n));
			if (sum < 64'sd0)
				v[n] = '0;
			else
				v[n] = expand_pkg::DATA_W'((sum >>> 14) & 64'h7fff);
		end
		return v;
	endfunction

	always @(posedge clk) begin
		if (rst_gen) begin
			slot       = 0;
			pix_cnt[0] = 0;
			pix_cnt[1] = 0;
			str_cnt[0] = 0;
			str_cnt[1] = 0;
			done_m     = '0;
			done_prev  = '0;
			err_cnt_o  = 0;
			chk_cnt_o  = 0;
			exp_q.delete();
			lay_q.delete();
		end else begin
			// Input side, fire2 first and finished layers ignored
			f2_act = layer_i.fire2_en && !done_m[0];
			f3_act = layer_i.fire3_en && !done_m[1] && !f2_act;
			if (!(f2_act || f3_act)) begin
				slot = 0;
			end else if (slot < expand_pkg::CHIN_NUM) begin
				pix_buf[slot[expand_pkg::ADDR_W-1:0]] = ifm_i;
				slot++;
			end else begin
				// Gap cycle closes the pixel
				cur_l = f3_act;
				exp_q.push_back(ref_vector(cur_l, pix_buf));
				lay_q.push_back(cur_l);
				pix_cnt[cur_l]++;
				if (pix_cnt[cur_l] == expand_pkg::PIXEL_NUM)
					done_m[cur_l] = 1'b1;
				slot = 0;
			end

			// Output side, one vector per strobe in pixel order
			if (ofm_valid_i) begin
				if (exp_q.size() == 0) begin
					err_cnt_o++;
					$display("Output strobe at %0t ns with no pixel pending", $time);
				end else begin
					exp_v = exp_q.pop_front();
					exp_l = lay_q.pop_front();
					str_cnt[exp_l]++;
					for (int n = 0; n < expand_pkg::LANE_NUM; n++) begin
						chk_cnt_o++;
						if (ofm_i[n] !== exp_v[n]) begin
							err_cnt_o++;
							$display("error %0t ns: fire%0d lane %0d expected %h actual %h",
								$time, exp_l ? 3 : 2, n, exp_v[n], ofm_i[n]);
						end
					end
				end
			end

			// Done levels rise after the last strobe and never fall
			done_now = {fire3_done_i, fire2_done_i};
			for (int l = 0; l < 2; l++) begin
				if (done_now[l] && !done_prev[l]) begin
					chk_cnt_o++;
					if (str_cnt[l] != expand_pkg::PIXEL_NUM) begin
						err_cnt_o++;
						$display("Fire%0d done rose after only %0d strobes at %0t ns",
							l + 2, str_cnt[l], $time);
					end
				end
				if (!done_now[l] && done_prev[l]) begin
					err_cnt_o++;
					$display("Fire%0d done level fell at %0t ns", l + 2, $time);
				end
			end
			done_prev = done_now;

			// Closing tally of strobes per layer
			if (end_i) begin
				chk_cnt_o++;
				if (exp_q.size() != 0 || str_cnt[0] != expand_pkg::PIXEL_NUM ||
						str_cnt[1] != expand_pkg::PIXEL_NUM) begin
					err_cnt_o++;
					$display("Wrong strobe count at end: fire2 %0d, fire3 %0d, pending %0d",
						str_cnt[0], str_cnt[1], exp_q.size());
				end
			end
		end
	end

endmodule

// ==== verification/tb_expand_1x1.sv ====
/* Expand 1x1 testbench */
`timescale 1ns/1ns

module tb_expand_1x1;

	localparam int CLK_NS     = 4;
	// Two full layers at pixel rate, then slack for reset, extras and drain
	localparam int TIMEOUT_NS =
		2 * expand_pkg::PIXEL_NUM * (expand_pkg::CHIN_NUM + 1) * CLK_NS + 200 * CLK_NS;

	logic                   clk;
	logic                   rst_gen;
	expand_pkg::layer_req_t layer_req;
	expand_pkg::data_t      ifm;
	expand_pkg::ofm_vec_t   ofm;
	logic                   ofm_valid;
	logic                   fire2_done;
	logic                   fire3_done;
	logic                   end_chk;
	int                     err_cnt;
	int                     chk_cnt;
	int                     idle_err;
	int                     idle_chk;
	integer                 seed = 32'h88a2_d544;

	initial clk = 1'b0;
	always #(CLK_NS / 2) clk = ~clk;

	expand_1x1_layer UUT (
		.clk         (clk),
		.rst_gen     (rst_gen),
		.layer_i     (layer_req),
		.ifm_i       (ifm),
		.ofm_o       (ofm),
		.ofm_valid_o (ofm_valid),
		.fire2_done_o(fire2_done),
		.fire3_done_o(fire3_done)
	);

	expand_checker u_check (
		.clk         (clk),
		.rst_gen     (rst_gen),
		.layer_i     (layer_req),
		.ifm_i       (ifm),
		.ofm_i       (ofm),
		.ofm_valid_i (ofm_valid),
		.fire2_done_i(fire2_done),
		.fire3_done_i(fire3_done),
		.end_i       (end_chk),
		.err_cnt_o   (err_cnt),
		.chk_cnt_o   (chk_cnt)
	);

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////
	// CHIN_NUM channels then a random gap value
	task automatic drive_pixel(input int layer, input logic f2, input logic f3,
			input int mode);
		expand_pkg::data_t w;
		expand_pkg::data_t v;
		for (int c = 0; c <= expand_pkg::CHIN_NUM; c++) begin
			w = expand_pkg::layer_weight(layer, c % expand_pkg::CHIN_NUM, 0);
			v = expand_pkg::data_t'($random(seed));
			// Extremes, modes 3 and 4 follow the lane 0 kernel signs
			if (c < expand_pkg::CHIN_NUM) begin
				case (mode)
					1: v = 16'sh7fff;
					2: v = 16'sh8000;
					3: v = w[expand_pkg::DATA_W-1] ? 16'sh8000 : 16'sh7fff;
					4: v = w[expand_pkg::DATA_W-1] ? 16'sh7fff : 16'sh8000;
					default: ;
				endcase
			end
			@(posedge clk);
			layer_req.fire2_en <= f2;
			layer_req.fire3_en <= f3;
			ifm                <= v;
		end
	endtask

	task automatic go_idle(input int n);
		repeat (n) begin
			@(posedge clk);
			layer_req <= '0;
			ifm       <= '0;
		end
	endtask

	// Extreme pixels first, random ones after
	task automatic run_layer(input int layer);
		for (int p = 0; p < expand_pkg::PIXEL_NUM; p++)
			drive_pixel(layer, layer == 0, layer == 1, (p < 5) ? p : 0);
		go_idle(1);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		rst_gen   = 1'b1;
		layer_req = '0;
		ifm       = '0;
		end_chk   = 1'b0;
		idle_err  = 0;
		idle_chk  = 0;
		repeat (2) @(posedge clk);
		rst_gen <= 1'b0;
		// Quiet outputs while no input arrives
		repeat (6) begin
			@(negedge clk);
			idle_chk++;
			if (ofm_valid || fire2_done || fire3_done) begin
				idle_err++;
				$display("Strobe or done level high after reset with no input at %0t ns",
					$time);
			end
		end
		run_layer(0);
		do @(negedge clk); while (!fire2_done);
		// Fire2 is finished, so these pixels give no strobe
		drive_pixel(0, 1'b1, 1'b0, 0);
		drive_pixel(0, 1'b1, 1'b0, 0);
		go_idle(1);
		run_layer(1);
		do @(negedge clk); while (!fire3_done);
		drive_pixel(1, 1'b1, 1'b1, 0);
		// Drain so that any stray strobe is still caught
		go_idle(12);
		end_chk <= 1'b1;
		@(posedge clk);
		@(negedge clk);
		$display("Checks: %0d, errors: %0d", chk_cnt + idle_chk, err_cnt + idle_err);
		if (err_cnt + idle_err == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
logic/expand_pkg.sv
logic/expand_param_rom.sv
logic/mac_lane.sv
logic/expand_sequencer.sv
logic/output_requant.sv
logic/expand_1x1_layer.sv
verification/expand_checker.sv
verification/tb_expand_1x1.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the expand 1x1 testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_expand_1x1 \
	--Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
